// ==== verilog.f ====
+incdir+bench
logic/idu_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_issue.sv
logic/idu_top.sv
bench/idu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the decode stage with its testbench and runs it, exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ns --top-module idu_tb \
    -f verilog.f --Mdir obj_dir -o idu_sim \
    && ./obj_dir/idu_sim \
    || { echo "build or simulation failed" >&2; exit 1; }

// ==== bench/idu_ref.svh ====
`ifndef IDU_REF_SVH
`define IDU_REF_SVH

// full period modulo 2**32
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// funct7 selects the M extension or the alternate form
function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic [6:0] f7);
    if (f7 == 7'h01) begin
        case (f3)
            3'd0:    return ALU_MUL;
            3'd1:    return ALU_MULH;
            3'd3:    return ALU_MULHU;
            3'd4:    return ALU_DIV;
            3'd5:    return ALU_DIVU;
            3'd6:    return ALU_REM;
            3'd7:    return ALU_REMU;
            default: return ALU_NOP;
        endcase
    end
    case (f3)
        3'd0:    return f7[5] ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return f7[5] ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// expected issue bundle, rs values already include a same-cycle writeback
function automatic issue_t predict_issue(input pc_t pc, input inst_t w,
                                         input xlen_t rs1_val, input xlen_t rs2_val);
    issue_t     e;
    xlen_t      imm;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       use1;
    logic       use2;
    logic       ok;
    f3   = w[14:12];
    f7   = w[31:25];
    e    = '0;
    imm  = {{20{w[31]}}, w[31:20]}; // I form unless overridden
    use1 = 1'b1;
    use2 = 1'b0;
    ok   = 1'b1;
    e.ctrl.wena  = 1'b1;
    e.ctrl.waddr = w[11:7];
    case (w[6:0])
        7'b0110011: begin
            e.ctrl.inst_type = INST_RR;
            e.ctrl.alu_op    = ref_alu(f3, f7);
            imm  = '0;
            use2 = 1'b1;
            ok   = f7 == 7'h00 || (f7 == 7'h01 && f3 != 3'd2) ||
                   (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        7'b0010011: begin
            e.ctrl.inst_type = INST_RI;
            e.ctrl.alu_op    = ref_alu(f3, (f3 == 3'd5) ? f7 : 7'h00);
            ok = !(f3 == 3'd1 && f7 != 7'h00) &&
                 !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        end
        7'b0000011: begin
            e.ctrl.inst_type = INST_LOAD;
            e.ctrl.wsel      = WSEL_LSU;
            case (f3)
                3'd0:    e.ctrl.lsu_op = LSU_LB;
                3'd1:    e.ctrl.lsu_op = LSU_LH;
                3'd2:    e.ctrl.lsu_op = LSU_LW;
                3'd4:    e.ctrl.lsu_op = LSU_LBU;
                3'd5:    e.ctrl.lsu_op = LSU_LHU;
                default: ok = 1'b0;
            endcase
        end
        7'b0100011: begin // rs2 is store data only, the offset is operand b
            e.ctrl.inst_type = INST_STORE;
            e.ctrl.wena      = 1'b0;
            e.ctrl.lsu_op    = (f3 == 3'd0) ? LSU_SB : (f3 == 3'd1) ? LSU_SH : LSU_SW;
            imm  = {{20{w[31]}}, w[31:25], w[11:7]};
            ok   = f3 <= 3'd2;
        end
        7'b1100011: begin
            e.ctrl.inst_type = INST_BRANCH;
            e.ctrl.wena      = 1'b0;
            imm  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            use2 = 1'b1;
            case (f3)
                3'd0:    e.ctrl.bpu_op = BPU_BEQ;
                3'd1:    e.ctrl.bpu_op = BPU_BNE;
                3'd4:    e.ctrl.bpu_op = BPU_BLT;
                3'd5:    e.ctrl.bpu_op = BPU_BGE;
                3'd6:    e.ctrl.bpu_op = BPU_BLTU;
                3'd7:    e.ctrl.bpu_op = BPU_BGEU;
                default: ok = 1'b0;
            endcase
        end
        7'b1101111: begin
            e.ctrl.inst_type = INST_JAL;
            e.ctrl.alu_op    = ALU_JUMP;
            e.ctrl.bpu_op    = BPU_JAL;
            imm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            use1 = 1'b0;
        end
        7'b1100111: begin
            e.ctrl.inst_type = INST_JALR;
            e.ctrl.alu_op    = ALU_JUMP;
            e.ctrl.bpu_op    = BPU_JALR;
            ok = f3 == 3'd0;
        end
        7'b0110111, 7'b0010111: begin // bit 5 tells lui from auipc
            e.ctrl.inst_type = w[5] ? INST_LUI : INST_AUIPC;
            e.ctrl.alu_op    = w[5] ? ALU_LUI : ALU_AUIPC;
            imm  = {w[31:12], 12'h000};
            use1 = 1'b0;
        end
        7'b1110011: begin
            e.ctrl.inst_type = INST_CSRR;
            if (f3 == 3'd1 || f3 == 3'd2) begin
                e.ctrl.alu_op    = ALU_CSRR;
                e.ctrl.csr_op    = (f3 == 3'd1) ? CSR_CSRRW : CSR_CSRRS;
                e.ctrl.csr_wena  = 1'b1;
                e.ctrl.csr_rena  = 1'b1;
                e.ctrl.csr_waddr = w[31:20];
                e.ctrl.csr_raddr = w[31:20];
            end else begin
                e.ctrl.wena   = 1'b0;
                e.ctrl.ebreak = w[31:20] == 12'h001;
                use1 = 1'b0;
                imm  = '0;
                ok   = f3 == 3'd0 &&
                       (w[31:20] == 12'h000 || w[31:20] == 12'h001 || w[31:20] == 12'h302);
                if (w[31:20] == 12'h000) begin // ecall saves pc and jumps to mtvec
                    e.ctrl.csr_op    = CSR_ECALL;
                    e.ctrl.csr_wena  = 1'b1;
                    e.ctrl.csr_waddr = 12'h341;
                    e.ctrl.csr_rena  = 1'b1;
                    e.ctrl.csr_raddr = 12'h305;
                end
                if (w[31:20] == 12'h302) begin
                    e.ctrl.csr_op    = CSR_MRET;
                    e.ctrl.csr_rena  = 1'b1;
                    e.ctrl.csr_raddr = 12'h341;
                end
            end
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        e.ctrl = '0;
        imm    = '0;
        use1   = 1'b0;
        use2   = 1'b0;
    end
    e.ctrl.illegal = !ok;
    e.pc  = pc;
    e.imm = imm;
    case (e.ctrl.inst_type)
        INST_AUIPC, INST_JAL, INST_JALR: e.op_a = pc;
        default:                         e.op_a = use1 ? rs1_val : '0;
    endcase
    e.op_b     = use2 ? rs2_val : imm;
    e.rs2_data = rs2_val; // read port 2 always rides along
    return e;
endfunction

`endif

// ==== bench/idu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module idu_tb
    import idu_pkg::*;
();

    localparam int          CLK_PERIOD = 20;
    localparam int          N_RAND     = 240;
    localparam int          MAX_CYCLES = 100 + 2 * N_RAND; // worst case with a gap per instruction
    localparam logic [31:0] SEED       = 32'hcda0803f;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    pc_t       pc;
    inst_t     inst_word;
    logic      wb_en;
    reg_addr_t wb_addr;
    xlen_t     wb_data;
    logic      issue_valid;
    issue_t    issue_out;

    logic [31:0] rng_state;
    xlen_t       shadow [32]; // mirrors the register file
    issue_t      exp_q [$];
    time         sent_q [$];
    int          n_sent;
    int          n_seen;

    `include "idu_ref.svh"

    idu_top DUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .inst_valid_i  (inst_valid),
        .pc_i          (pc),
        .inst_i        (inst_word),
        .wb_en_i       (wb_en),
        .wb_addr_i     (wb_addr),
        .wb_data_i     (wb_data),
        .issue_valid_o (issue_valid),
        .issue_o       (issue_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    // random fields, kind picks the opcode class
    function automatic inst_t make_inst(input int kind);
        logic [31:0] r;
        inst_t       w;
        r = rand32();
        case (kind)
            0:  w = {r[29] ? 7'h20 : 7'h00, r[24:7], 7'b0110011};
            1:  w = {7'h01, r[24:7], 7'b0110011};
            2: begin
                w = {r[31:7], 7'b0010011};
                if (w[13:12] == 2'b01) // shift immediates
                    w[31:25] = r[29] ? 7'h20 : 7'h00;
            end
            3:  w = {r[31:7], 7'b0000011};
            4:  w = {r[31:7], 7'b0100011};
            5:  w = {r[31:7], 7'b1100011};
            6:  w = {r[31:7], 7'b1101111};
            7:  w = {r[31:15], 3'b000, r[11:7], 7'b1100111};
            8:  w = {r[31:7], 7'b0110111};
            9:  w = {r[31:7], 7'b0010111};
            10: w = {r[31:15], 1'b0, r[29], ~r[29], r[11:7], 7'b1110011}; // csrrw or csrrs
            11: w = {12'h000, r[19:15], 3'b000, r[11:7], 7'b1110011};
            12: w = {12'h302, r[19:15], 3'b000, r[11:7], 7'b1110011};
            13: w = {12'h001, r[19:15], 3'b000, r[11:7], 7'b1110011};
            default: w = {r[31:7], 7'b0001011}; // custom-0 space
        endcase
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic compare_issue(input issue_t exp, input issue_t got);
        check_value("pc", got.pc, exp.pc);
        check_value("imm", got.imm, exp.imm);
        check_value("op_a", got.op_a, exp.op_a);
        check_value("op_b", got.op_b, exp.op_b);
        check_value("rs2_data", got.rs2_data, exp.rs2_data);
        check_value("inst_type", 32'(got.ctrl.inst_type), 32'(exp.ctrl.inst_type));
        check_value("alu_op", 32'(got.ctrl.alu_op), 32'(exp.ctrl.alu_op));
        check_value("lsu_op", 32'(got.ctrl.lsu_op), 32'(exp.ctrl.lsu_op));
        check_value("bpu_op", 32'(got.ctrl.bpu_op), 32'(exp.ctrl.bpu_op));
        check_value("csr_op", 32'(got.ctrl.csr_op), 32'(exp.ctrl.csr_op));
        check_value("wsel", 32'(got.ctrl.wsel), 32'(exp.ctrl.wsel));
        check_value("wena", 32'(got.ctrl.wena), 32'(exp.ctrl.wena));
        check_value("waddr", 32'(got.ctrl.waddr), 32'(exp.ctrl.waddr));
        check_value("csr_wena", 32'(got.ctrl.csr_wena), 32'(exp.ctrl.csr_wena));
        check_value("csr_waddr", 32'(got.ctrl.csr_waddr), 32'(exp.ctrl.csr_waddr));
        check_value("csr_rena", 32'(got.ctrl.csr_rena), 32'(exp.ctrl.csr_rena));
        check_value("csr_raddr", 32'(got.ctrl.csr_raddr), 32'(exp.ctrl.csr_raddr));
        check_value("ebreak", 32'(got.ctrl.ebreak), 32'(exp.ctrl.ebreak));
        check_value("illegal", 32'(got.ctrl.illegal), 32'(exp.ctrl.illegal));
    endtask

    // one clock of stimulus, the shadow takes the writeback before the read
    task automatic drive(input logic strobe, input inst_t w, input logic wb,
                         input reg_addr_t wa, input xlen_t wd);
        pc_t p;
        p = rand32() & 32'hffff_fffc;
        @(posedge clk);
        inst_valid <= strobe;
        inst_word  <= w;
        pc         <= p;
        wb_en      <= wb;
        wb_addr    <= wa;
        wb_data    <= wd;
        if (wb && wa != 5'd0)
            shadow[wa] = wd;
        if (strobe) begin
            exp_q.push_back(predict_issue(p, w, shadow[w[19:15]], shadow[w[24:20]]));
            sent_q.push_back($time);
            n_sent++;
        end
    endtask

    initial begin
        inst_t       w;
        logic [31:0] r;
        rng_state  = SEED;
        n_sent     = 0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        pc         = '0;
        inst_word  = '0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) drive(1'b0, '0, 1'b0, '0, '0);
        for (int k = 0; k < 32; k++) begin // x0 gets a write too
            drive(1'b0, '0, 1'b1, 5'(k), rand32());
        end
        for (int k = 0; k < 32; k++) begin
            drive(1'b1, {7'h00, 5'(31 - k), 5'(k), 3'b000, 5'(k), 7'b0110011}, 1'b0, '0, '0);
        end
        // writeback and read of the same register in one cycle
        drive(1'b1, {7'h00, 5'd9, 5'd7, 3'b000, 5'd5, 7'b0110011}, 1'b1, 5'd7, 32'h1357_9bdf);
        drive(1'b1, {7'h01, 5'd3, 5'd7, 3'b010, 5'd8, 7'b0100011}, 1'b1, 5'd3, 32'h2468_ace0);
        for (int i = 0; i < N_RAND; i++) begin
            r = rand32();
            if (r[31:30] == 2'b00)
                drive(1'b0, '0, 1'b0, '0, '0);
            w = make_inst(i % 15);
            r = rand32();
            drive(1'b1, w, r[31], r[30:26], rand32());
        end
        repeat (2) drive(1'b0, '0, 1'b0, '0, '0);
        while (n_seen != n_sent) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk); // quiet tail after the last issue
        $display("** PASS **");
        $finish;
    end

    // outputs are sampled on the falling edge, away from the driving edge
    initial begin
        issue_t idle;
        time    t_sent;
        idle   = '0;
        n_seen = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (issue_valid && n_seen >= n_sent) begin
                $display("issue at %0t ns arrived with no instruction outstanding", $time);
                $display("** FAIL **");
                $fatal(1, "unexpected issue");
            end else if (issue_valid) begin
                t_sent = sent_q[n_seen];
                check_value("issue latency ns", 32'($time - t_sent),
                            32'(CLK_PERIOD + CLK_PERIOD / 2));
                compare_issue(exp_q[n_seen], issue_out);
                n_seen++;
            end else if (n_seen == 0) begin
                compare_issue(idle, issue_out); // quiet until the first issue
            end
        end
    end

    initial begin
        #((MAX_CYCLES + 50) * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not complete", MAX_CYCLES + 50);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== logic/idu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module idu_top
    import idu_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            inst_valid_i,
    input  wire pc_t       pc_i,
    input  wire inst_t     inst_i,
    input  wire            wb_en_i,
    input  wire reg_addr_t wb_addr_i,
    input  wire xlen_t     wb_data_i,
    output logic           issue_valid_o,
    output issue_t         issue_o
);

    dec_ctrl_t ctrl;
    xlen_t     imm;
    logic      rena1;
    logic      rena2;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    inst_decoder u_decoder (
        .inst_i   (inst_i),
        .ctrl_o   (ctrl),
        .imm_o    (imm),
        .rena1_o  (rena1),
        .rena2_o  (rena2),
        .raddr1_o (raddr1),
        .raddr2_o (raddr2)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_en_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    operand_issue u_issue (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (inst_valid_i),
        .pc_i       (pc_i),
        .ctrl_i     (ctrl),
        .imm_i      (imm),
        .rena1_i    (rena1),
        .rena2_i    (rena2),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .valid_o    (issue_valid_o),
        .issue_o    (issue_o)
    );

endmodule

`default_nettype wire

// ==== logic/operand_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_issue
    import idu_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            valid_i,
    input  wire pc_t       pc_i,
    input  wire dec_ctrl_t ctrl_i,
    input  wire xlen_t     imm_i,
    input  wire            rena1_i,
    input  wire            rena2_i,
    input  wire xlen_t     rs1_data_i,
    input  wire xlen_t     rs2_data_i,
    output logic           valid_o,
    output issue_t         issue_o
);

    xlen_t op_a;
    xlen_t op_b;
    logic  pc_as_a;

    assign pc_as_a = ctrl_i.inst_type inside {INST_AUIPC, INST_JAL, INST_JALR};
    assign op_a    = pc_as_a ? pc_i : (rena1_i ? rs1_data_i : '0);

    // store address is rs1 + imm, rs2 rides along as store data
    assign op_b = rena2_i ? rs2_data_i : imm_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            issue_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                issue_o.pc       <= pc_i;
                issue_o.imm      <= imm_i;
                issue_o.op_a     <= op_a;
                issue_o.op_b     <= op_b;
                issue_o.rs2_data <= rs2_data_i;
                issue_o.ctrl     <= ctrl_i;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !valid_o && issue_o == '0)
        else $error("issue register not clear after reset");

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import idu_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            we_i,
    input  wire reg_addr_t waddr_i,
    input  wire xlen_t     wdata_i,
    input  wire reg_addr_t raddr1_i,
    input  wire reg_addr_t raddr2_i,
    output xlen_t          rdata1_o,
    output xlen_t          rdata2_o
);

    xlen_t regs [1:31]; // x0 has no storage
    logic  wr_live;

    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback in the same cycle is forwarded
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_live && raddr1_i == waddr_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_live && raddr2_i == waddr_i) ? wdata_i : regs[raddr2_i];

    // a write aimed at x0 never becomes visible later
    x0_stays_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (we_i && waddr_i == '0) |=>
            (raddr1_i != '0 || rdata1_o == '0) && (raddr2_i != '0 || rdata2_o == '0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
    import idu_pkg::*;
(
    input  wire inst_t inst_i,
    output dec_ctrl_t  ctrl_o,
    output xlen_t      imm_o,
    output logic       rena1_o,
    output logic       rena2_o,
    output reg_addr_t  raddr1_o,
    output reg_addr_t  raddr2_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    reg_addr_t   rd;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;
    logic        legal;

    assign opcode  = inst_i[6:0];
    assign rd      = inst_i[11:7];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign funct12 = inst_i[31:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign raddr1_o = inst_i[19:15];
    assign raddr2_o = inst_i[24:20];

    // shared by reg-reg and reg-imm forms
    function automatic alu_op_e alu_base(logic [2:0] f3);
        case (f3)
            F3_ADD:  return ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        ctrl_o       = '0;
        imm_o        = '0;
        rena1_o      = 1'b0;
        rena2_o      = 1'b0;
        legal        = 1'b1;
        ctrl_o.waddr = rd;
        case (opcode)
            OPC_OP: begin
                ctrl_o.inst_type = INST_RR;
                ctrl_o.wena      = 1'b1;
                rena1_o          = 1'b1;
                rena2_o          = 1'b1;
                if (funct7 == F7_MULDIV) begin
                    case (funct3)
                        F3_MUL:   ctrl_o.alu_op = ALU_MUL;
                        F3_MULH:  ctrl_o.alu_op = ALU_MULH;
                        F3_MULHU: ctrl_o.alu_op = ALU_MULHU;
                        F3_DIV:   ctrl_o.alu_op = ALU_DIV;
                        F3_DIVU:  ctrl_o.alu_op = ALU_DIVU;
                        F3_REM:   ctrl_o.alu_op = ALU_REM;
                        F3_REMU:  ctrl_o.alu_op = ALU_REMU;
                        default:  legal = 1'b0; // mulhsu not in this core
                    endcase
                end else if (funct7 == F7_ALT) begin
                    case (funct3)
                        F3_ADD:  ctrl_o.alu_op = ALU_SUB;
                        F3_SR:   ctrl_o.alu_op = ALU_SRA;
                        default: legal = 1'b0;
                    endcase
                end else if (funct7 == F7_BASE) begin
                    ctrl_o.alu_op = alu_base(funct3);
                end else begin
                    legal = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                ctrl_o.inst_type = INST_RI;
                ctrl_o.wena      = 1'b1;
                ctrl_o.alu_op    = alu_base(funct3);
                rena1_o          = 1'b1;
                imm_o            = imm_i;
                if (funct3 == F3_SLL && funct7 != F7_BASE)
                    legal = 1'b0;
                if (funct3 == F3_SR && funct7 == F7_ALT)
                    ctrl_o.alu_op = ALU_SRA;
                else if (funct3 == F3_SR && funct7 != F7_BASE)
                    legal = 1'b0;
            end
            OPC_LOAD: begin
                ctrl_o.inst_type = INST_LOAD;
                ctrl_o.wena      = 1'b1;
                ctrl_o.wsel      = WSEL_LSU;
                rena1_o          = 1'b1;
                imm_o            = imm_i;
                case (funct3)
                    F3_LB:   ctrl_o.lsu_op = LSU_LB;
                    F3_LH:   ctrl_o.lsu_op = LSU_LH;
                    F3_LW:   ctrl_o.lsu_op = LSU_LW;
                    F3_LBU:  ctrl_o.lsu_op = LSU_LBU;
                    F3_LHU:  ctrl_o.lsu_op = LSU_LHU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                ctrl_o.inst_type = INST_STORE;
                rena1_o          = 1'b1; // rs2 goes out as store data, not as an operand
                imm_o            = imm_s;
                case (funct3)
                    F3_SB:   ctrl_o.lsu_op = LSU_SB;
                    F3_SH:   ctrl_o.lsu_op = LSU_SH;
                    F3_SW:   ctrl_o.lsu_op = LSU_SW;
                    default: legal = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                ctrl_o.inst_type = INST_BRANCH;
                rena1_o          = 1'b1;
                rena2_o          = 1'b1;
                imm_o            = imm_b;
                case (funct3)
                    F3_BEQ:  ctrl_o.bpu_op = BPU_BEQ;
                    F3_BNE:  ctrl_o.bpu_op = BPU_BNE;
                    F3_BLT:  ctrl_o.bpu_op = BPU_BLT;
                    F3_BGE:  ctrl_o.bpu_op = BPU_BGE;
                    F3_BLTU: ctrl_o.bpu_op = BPU_BLTU;
                    F3_BGEU: ctrl_o.bpu_op = BPU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                ctrl_o.inst_type = INST_JAL;
                ctrl_o.alu_op    = ALU_JUMP; // link address pc + 4
                ctrl_o.bpu_op    = BPU_JAL;
                ctrl_o.wena      = 1'b1;
                imm_o            = imm_j;
            end
            OPC_JALR: begin
                ctrl_o.inst_type = INST_JALR;
                ctrl_o.alu_op    = ALU_JUMP;
                ctrl_o.bpu_op    = BPU_JALR;
                ctrl_o.wena      = 1'b1;
                rena1_o          = 1'b1;
                imm_o            = imm_i;
                legal            = (funct3 == F3_JALR);
            end
            OPC_LUI: begin
                ctrl_o.inst_type = INST_LUI;
                ctrl_o.alu_op    = ALU_LUI;
                ctrl_o.wena      = 1'b1;
                imm_o            = imm_u;
            end
            OPC_AUIPC: begin
                ctrl_o.inst_type = INST_AUIPC;
                ctrl_o.alu_op    = ALU_AUIPC;
                ctrl_o.wena      = 1'b1;
                imm_o            = imm_u;
            end
            OPC_SYSTEM: begin
                ctrl_o.inst_type = INST_CSRR;
                case (funct3)
                    F3_CSRRW, F3_CSRRS: begin
                        ctrl_o.alu_op    = ALU_CSRR;
                        ctrl_o.csr_op    = (funct3 == F3_CSRRW) ? CSR_CSRRW : CSR_CSRRS;
                        ctrl_o.wena      = 1'b1;
                        ctrl_o.csr_wena  = 1'b1;
                        ctrl_o.csr_rena  = 1'b1;
                        ctrl_o.csr_waddr = imm_i[11:0];
                        ctrl_o.csr_raddr = imm_i[11:0];
                        rena1_o          = 1'b1;
                        imm_o            = imm_i;
                    end
                    F3_PRIV: begin
                        case (funct12)
                            F12_ECALL: begin
                                ctrl_o.csr_op    = CSR_ECALL;
                                ctrl_o.csr_wena  = 1'b1; // save pc to mepc
                                ctrl_o.csr_waddr = CSR_MEPC;
                                ctrl_o.csr_rena  = 1'b1; // trap target
                                ctrl_o.csr_raddr = CSR_MTVEC;
                            end
                            F12_MRET: begin
                                ctrl_o.csr_op    = CSR_MRET;
                                ctrl_o.csr_rena  = 1'b1;
                                ctrl_o.csr_raddr = CSR_MEPC;
                            end
                            F12_EBREAK: ctrl_o.ebreak = 1'b1;
                            default:    legal = 1'b0;
                        endcase
                    end
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl_o  = '0;
            imm_o   = '0;
            rena1_o = 1'b0;
            rena2_o = 1'b0;
        end
        ctrl_o.illegal = !legal;
    end

    // an unknown word must not disturb any architectural state downstream
    always_comb begin
        assert (!ctrl_o.illegal || (!ctrl_o.wena && !ctrl_o.csr_wena && ctrl_o.lsu_op == LSU_NOP))
            else $error("illegal instruction %h decoded with side effects", inst_i);
    end

endmodule

`default_nettype wire

// ==== logic/idu_pkg.sv ====
`default_nettype none

package idu_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    localparam logic [6:0] OPC_OP      = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM  = 7'b001_0011;
    localparam logic [6:0] OPC_LOAD    = 7'b000_0011;
    localparam logic [6:0] OPC_STORE   = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH  = 7'b110_0011;
    localparam logic [6:0] OPC_JAL     = 7'b110_1111;
    localparam logic [6:0] OPC_JALR    = 7'b110_0111;
    localparam logic [6:0] OPC_LUI     = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC   = 7'b001_0111;
    localparam logic [6:0] OPC_SYSTEM  = 7'b111_0011;

    localparam logic [2:0] F3_ADD      = 3'd0; // also sub
    localparam logic [2:0] F3_SLL      = 3'd1;
    localparam logic [2:0] F3_SLT      = 3'd2;
    localparam logic [2:0] F3_SLTU     = 3'd3;
    localparam logic [2:0] F3_XOR      = 3'd4;
    localparam logic [2:0] F3_SR       = 3'd5; // srl and sra
    localparam logic [2:0] F3_OR       = 3'd6;
    localparam logic [2:0] F3_AND      = 3'd7;

    localparam logic [2:0] F3_MUL      = 3'd0;
    localparam logic [2:0] F3_MULH     = 3'd1;
    localparam logic [2:0] F3_MULHU    = 3'd3;
    localparam logic [2:0] F3_DIV      = 3'd4;
    localparam logic [2:0] F3_DIVU     = 3'd5;
    localparam logic [2:0] F3_REM      = 3'd6;
    localparam logic [2:0] F3_REMU     = 3'd7;

    localparam logic [2:0] F3_LB       = 3'd0;
    localparam logic [2:0] F3_LH       = 3'd1;
    localparam logic [2:0] F3_LW       = 3'd2;
    localparam logic [2:0] F3_LBU      = 3'd4;
    localparam logic [2:0] F3_LHU      = 3'd5;
    localparam logic [2:0] F3_SB       = 3'd0;
    localparam logic [2:0] F3_SH       = 3'd1;
    localparam logic [2:0] F3_SW       = 3'd2;

    localparam logic [2:0] F3_BEQ      = 3'd0;
    localparam logic [2:0] F3_BNE      = 3'd1;
    localparam logic [2:0] F3_BLT      = 3'd4;
    localparam logic [2:0] F3_BGE      = 3'd5;
    localparam logic [2:0] F3_BLTU     = 3'd6;
    localparam logic [2:0] F3_BGEU     = 3'd7;
    localparam logic [2:0] F3_JALR     = 3'd0;

    localparam logic [2:0] F3_PRIV     = 3'd0; // ecall, ebreak, mret
    localparam logic [2:0] F3_CSRRW    = 3'd1;
    localparam logic [2:0] F3_CSRRS    = 3'd2;

    localparam logic [6:0] F7_BASE     = 7'h00;
    localparam logic [6:0] F7_ALT      = 7'h20; // sub, sra, srai
    localparam logic [6:0] F7_MULDIV   = 7'h01;

    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;

    typedef enum logic [3:0] {
        INST_NOP, INST_RR, INST_RI, INST_LOAD, INST_STORE, INST_BRANCH,
        INST_JAL, INST_JALR, INST_LUI, INST_AUIPC, INST_CSRR
    } inst_type_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JUMP, ALU_LUI, ALU_AUIPC, ALU_CSRR,
        ALU_MUL, ALU_MULH, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NOP, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    typedef enum logic [3:0] {
        BPU_NOP, BPU_BEQ, BPU_BNE, BPU_BLT, BPU_BGE, BPU_BLTU, BPU_BGEU, BPU_JAL, BPU_JALR
    } bpu_op_e;

    typedef enum logic [2:0] {
        CSR_NOP, CSR_CSRRW, CSR_CSRRS, CSR_ECALL, CSR_MRET
    } csr_op_e;

    typedef enum logic [0:0] {
        WSEL_ALU, WSEL_LSU
    } wsel_e;

    typedef struct packed {
        inst_type_e inst_type;
        alu_op_e    alu_op;
        lsu_op_e    lsu_op;
        bpu_op_e    bpu_op;
        csr_op_e    csr_op;
        wsel_e      wsel;
        logic       wena;
        reg_addr_t  waddr;
        logic       csr_wena;
        csr_addr_t  csr_waddr;
        logic       csr_rena;
        csr_addr_t  csr_raddr;
        logic       ebreak;
        logic       illegal;
    } dec_ctrl_t;

    typedef struct packed {
        pc_t       pc;
        xlen_t     imm;
        xlen_t     op_a;
        xlen_t     op_b;
        xlen_t     rs2_data; // store data
        dec_ctrl_t ctrl;
    } issue_t;

endpackage

`default_nettype wire
